// File: compile.f
+incdir+verification
hdl/rvIsaPkg.sv
hdl/wbBusPkg.sv
hdl/coreIfs.sv
hdl/fetchUnit.sv
hdl/execUnit.sv
hdl/lsuUnit.sv
hdl/riscvCore.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing -j 0 --top-module coreTb -f compile.f; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/VcoreTb > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// File: verification/coreRefModel.svh
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// I type, funct3 is 010 for loads and 000 otherwise
function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, (op == opLoad) ? 3'b010 : 3'b000, rd, op};
endfunction

// register ops always read x1 and x2
function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd);
	return {f7, 5'd2, 5'd1, f3, rd, opOp};
endfunction

// word store, base register x10
function automatic logic [31:0] encodeS(input logic [4:0] rs2, input logic [11:0] imm);
	return {imm[11:5], rs2, 5'd10, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] encodeB(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encodeJ(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// contents of data words never written
function automatic logic [31:0] fillWord(input logic [31:0] a);
	return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
endfunction

function automatic void buildProgram();
	logic [11:0] r1;
	logic [11:0] r2;
	int k;
	r1 = 12'($urandom);
	r2 = 12'($urandom);
	progMem.push_back({20'h00001, 5'd10, opLui});
	progMem.push_back(encodeI(opOpImm, 5'd1, 5'd0, r1));
	progMem.push_back(encodeI(opOpImm, 5'd2, 5'd0, r2));
	progMem.push_back(encodeI(opOpImm, 5'd9, 5'd10, r2));
	progMem.push_back(encodeR(7'h00, 3'd0, 5'd3));
	progMem.push_back(encodeR(7'h20, 3'd0, 5'd4));
	progMem.push_back(encodeR(7'h00, 3'd7, 5'd5));
	progMem.push_back(encodeR(7'h00, 3'd6, 5'd6));
	progMem.push_back(encodeR(7'h00, 3'd4, 5'd7));
	progMem.push_back(encodeR(7'h00, 3'd2, 5'd8));
	// x3 to x10 to 0x1000 upward
	for (k = 3; k <= 10; k++) begin
		progMem.push_back(encodeS(5'(k), 12'((k - 3) * 4)));
	end
	progMem.push_back(encodeI(opLoad, 5'd11, 5'd10, 12'd4));
	progMem.push_back(encodeI(opLoad, 5'd12, 5'd10, 12'd20));
	progMem.push_back(encodeS(5'd11, 12'd32));
	progMem.push_back(encodeS(5'd12, 12'd36));
	// x15 known before the branch block
	progMem.push_back(encodeI(opOpImm, 5'd15, 5'd0, 12'd0));
	// taken beq, untaken bne and beq, taken bne, then jal; x15 writes are skipped
	progMem.push_back(encodeB(3'b000, 5'd1, 5'd1, 13'd8));
	progMem.push_back(encodeI(opOpImm, 5'd15, 5'd0, 12'd1));
	progMem.push_back(encodeB(3'b001, 5'd1, 5'd1, 13'd8));
	progMem.push_back(encodeB(3'b000, 5'd10, 5'd0, 13'd8));
	progMem.push_back(encodeB(3'b001, 5'd10, 5'd0, 13'd8));
	progMem.push_back(encodeI(opOpImm, 5'd15, 5'd0, 12'd2));
	progMem.push_back(encodeJ(5'd16, 21'd8));
	progMem.push_back(encodeI(opOpImm, 5'd15, 5'd0, 12'd3));
	progMem.push_back(encodeS(5'd15, 12'd40));
	progMem.push_back(encodeS(5'd16, 12'd44));
	progMem.push_back(encodeJ(5'd0, 21'd0));
endfunction

// runs the image up to the jump to self, filling the fetch and store lists
function automatic void runReference();
	logic [31:0] x [32];
	logic [31:0] mem [logic [31:0]];
	logic [31:0] pc;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] immI;
	logic [31:0] adr;
	logic [31:0] res;
	logic [31:0] nxt;
	x = '{default: '0};
	pc = resetPc;
	while (expFetch.size() < 200) begin
		if (int'(pc >> 2) >= progMem.size()) begin
			break;
		end
		ins = progMem[pc >> 2];
		expFetch.push_back(pc);
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		res = pc + 32'd4;
		nxt = pc + 32'd4;
		case (ins[6:0])
			opLui: res = {ins[31:12], 12'h000};
			opOpImm: res = a + immI;
			opOp: begin
				case (ins[14:12])
					3'd0: res = ins[30] ? a - b : a + b;
					3'd2: res = {31'd0, $signed(a) < $signed(b)};
					3'd4: res = a ^ b;
					3'd6: res = a | b;
					default: res = a & b;
				endcase
			end
			opLoad: begin
				adr = a + immI;
				res = mem.exists(adr) ? mem[adr] : fillWord(adr);
			end
			opStore: begin
				adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				mem[adr] = b;
				expStoreAdr.push_back(adr);
				expStoreDat.push_back(b);
			end
			opBranch: begin
				if ((a == b) != ins[12]) begin
					nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			opJal: nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			default: ;
		endcase
		if (ins[6:0] != opStore && ins[6:0] != opBranch && ins[11:7] != 5'd0) begin
			x[ins[11:7]] = res;
		end
		if (nxt == pc) begin
			break;
		end
		pc = nxt;
	end
endfunction

`endif

// File: verification/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb import rvIsaPkg::*, wbBusPkg::*; ();

	logic clk_mem;
	logic rst = 1'b1;
	logic ibus_cyc_o;
	logic ibus_stb_o;
	logic [31:0] ibus_adr_o;
	logic ibus_ack_i = 1'b0;
	logic [31:0] ibus_dat_i = '0;
	logic dbus_cyc_o;
	logic dbus_stb_o;
	logic dbus_we_o;
	logic [31:0] dbus_adr_o;
	logic [31:0] dbus_dat_o;
	logic [3:0] dbus_sel_o;
	logic [31:0] dbus_dat_i = '0;
	logic dbus_ack_i = 1'b0;

	logic [31:0] progMem [$];
	logic [31:0] dataMem [logic [31:0]];
	logic [31:0] expFetch [$];
	logic [31:0] expStoreAdr [$];
	logic [31:0] expStoreDat [$];
	logic [31:0] gotFetch [$];
	logic [31:0] gotStoreAdr [$];
	logic [31:0] gotStoreDat [$];

	logic iPending = 1'b0;
	logic dPending = 1'b0;
	int iWait;
	int dWait;
	logic [31:0] iAdrHeld;
	logic [31:0] dAdrHeld;
	logic [32:0] dWrHeld;
	logic [31:0] seenAdr;
	logic [31:0] seenDat;
	logic [31:0] expAdr;
	int busErrors = 0;
	int traceErrors = 0;
	int endErrors = 0;
	int fetchIdx = 0;
	int storeIdx = 0;
	int cycles = 0;
	int cycleLimit;
	int seed;

	`include "coreRefModel.svh"

	riscvCore uut (.*);

	initial begin
		clk_mem = 1'b0;
		forever #50 clk_mem = ~clk_mem;
	end

	always @(negedge clk_mem) begin
		if (!rst) begin
			cycles++;
		end
	end

	task automatic checkBusIdle();
		assert (!ibus_cyc_o && !ibus_stb_o && !dbus_cyc_o && !dbus_stb_o && !dbus_we_o)
		else begin
			endErrors++;
			$display("bus cycle active while reset is applied");
		end
	endtask

	// instruction memory, 0 to 3 wait states per fetch
	always @(negedge clk_mem) begin
		if (rst) begin
			ibus_ack_i = 1'b0;
			iPending = 1'b0;
		end else if (ibus_ack_i) begin
			ibus_ack_i = 1'b0;
			// cyc and stb drop together the cycle after ack
			assert (!ibus_cyc_o && !ibus_stb_o) else begin
				busErrors++;
				$display("instruction bus cycle still open after ack");
			end
		end else if (ibus_stb_o) begin
			assert (ibus_cyc_o) else begin
				busErrors++;
				$display("ibus_stb_o high without ibus_cyc_o");
			end
			if (!iPending) begin
				iPending = 1'b1;
				iWait = int'($urandom % 4);
				iAdrHeld = ibus_adr_o;
			end
			assert (ibus_adr_o == iAdrHeld) else begin
				busErrors++;
				$display("Mismatch ibus_adr_o during wait: got %h expected %h",
					ibus_adr_o, iAdrHeld);
			end
			if (iWait == 0) begin
				assert (int'(ibus_adr_o >> 2) < progMem.size()) else begin
					busErrors++;
					$display("fetch outside the program image at %h", ibus_adr_o);
				end
				ibus_dat_i = progMem[ibus_adr_o >> 2];
				ibus_ack_i = 1'b1;
				iPending = 1'b0;
				gotFetch.push_back(ibus_adr_o);
			end else begin
				iWait--;
			end
		end else begin
			assert (!iPending) else begin
				busErrors++;
				$display("instruction bus cycle dropped before ack");
			end
			assert (!ibus_cyc_o) else begin
				busErrors++;
				$display("ibus_cyc_o high without ibus_stb_o");
			end
		end
	end

	// data memory
	always @(negedge clk_mem) begin
		if (rst) begin
			dbus_ack_i = 1'b0;
			dPending = 1'b0;
		end else if (dbus_ack_i) begin
			dbus_ack_i = 1'b0;
			assert (!dbus_cyc_o && !dbus_stb_o) else begin
				busErrors++;
				$display("data bus cycle still open after ack");
			end
		end else if (dbus_stb_o) begin
			assert (dbus_cyc_o) else begin
				busErrors++;
				$display("dbus_stb_o high without dbus_cyc_o");
			end
			if (!dPending) begin
				dPending = 1'b1;
				dWait = int'($urandom % 4);
				dAdrHeld = dbus_adr_o;
				dWrHeld = {dbus_we_o, dbus_dat_o};
			end
			assert (dbus_adr_o == dAdrHeld) else begin
				busErrors++;
				$display("Mismatch dbus_adr_o during wait: got %h expected %h",
					dbus_adr_o, dAdrHeld);
			end
			assert ({dbus_we_o, dbus_dat_o} == dWrHeld) else begin
				busErrors++;
				$display("Mismatch dbus_we_o/dbus_dat_o during wait: got %h expected %h",
					{dbus_we_o, dbus_dat_o}, dWrHeld);
			end
			if (dWait == 0) begin
				assert (dbus_sel_o == 4'hf) else begin
					busErrors++;
					$display("Mismatch dbus_sel_o: got %h expected %h", dbus_sel_o, 4'hf);
				end
				if (dbus_we_o) begin
					dataMem[dbus_adr_o] = dbus_dat_o;
					gotStoreAdr.push_back(dbus_adr_o);
					gotStoreDat.push_back(dbus_dat_o);
				end else begin
					dbus_dat_i = dataMem.exists(dbus_adr_o) ? dataMem[dbus_adr_o] :
						fillWord(dbus_adr_o);
				end
				dbus_ack_i = 1'b1;
				dPending = 1'b0;
			end else begin
				dWait--;
			end
		end else begin
			assert (!dPending) else begin
				busErrors++;
				$display("data bus cycle dropped before ack");
			end
			assert (!dbus_cyc_o) else begin
				busErrors++;
				$display("dbus_cyc_o high without dbus_stb_o");
			end
		end
	end

	// compare fetches and stores against the reference lists
	always @(negedge clk_mem) begin
		while (gotFetch.size() > 0) begin
			seenAdr = gotFetch.pop_front();
			expAdr = (fetchIdx < expFetch.size()) ? expFetch[fetchIdx] : expFetch[$];
			assert (seenAdr == expAdr) else begin
				traceErrors++;
				$display("Mismatch ibus_adr_o at fetch %0d: got %h expected %h",
					fetchIdx, seenAdr, expAdr);
			end
			fetchIdx++;
		end
		while (gotStoreAdr.size() > 0) begin
			seenAdr = gotStoreAdr.pop_front();
			seenDat = gotStoreDat.pop_front();
			assert (storeIdx < expStoreAdr.size()) else begin
				traceErrors++;
				$display("store %0d has no counterpart in the reference", storeIdx);
			end
			if (storeIdx < expStoreAdr.size()) begin
				assert (seenAdr == expStoreAdr[storeIdx]) else begin
					traceErrors++;
					$display("Mismatch dbus_adr_o at store %0d: got %h expected %h",
						storeIdx, seenAdr, expStoreAdr[storeIdx]);
				end
				assert (seenDat == expStoreDat[storeIdx]) else begin
					traceErrors++;
					$display("Mismatch dbus_dat_o at store %0d: got %h expected %h",
						storeIdx, seenDat, expStoreDat[storeIdx]);
				end
			end
			storeIdx++;
		end
	end

	initial begin
		seed = $urandom(91);
		buildProgram();
		runReference();
		// worst case per instruction: fetch and data with 3 waits each, plus overhead
		cycleLimit = expFetch.size() * ((1 + 3) + (1 + 3) + 2) + 50;
		repeat (4) begin
			@(negedge clk_mem);
			checkBusIdle();
		end
		rst = 1'b0;
		// done once the jump to self is fetched a second time
		while (fetchIdx <= expFetch.size() && cycles < cycleLimit) begin
			@(negedge clk_mem);
		end
		assert (fetchIdx > expFetch.size()) else begin
			endErrors++;
			$display("timeout after %0d cycles before the final jump was reached", cycles);
		end
		assert (storeIdx == expStoreAdr.size()) else begin
			endErrors++;
			$display("wrong number of stores: %0d seen, %0d expected",
				storeIdx, expStoreAdr.size());
		end
		$display("fetches %0d/%0d stores %0d/%0d errors bus %0d trace %0d end %0d",
			fetchIdx, expFetch.size(), storeIdx, expStoreAdr.size(),
			busErrors, traceErrors, endErrors);
		if (busErrors == 0 && traceErrors == 0 && endErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/riscvCore.sv
`timescale 1ns/1ps
`default_nettype none

module riscvCore import wbBusPkg::*; (
	input logic clk_mem,
	input logic rst,

	output logic ibus_cyc_o,
	output logic ibus_stb_o,
	output logic [adrW-1:0] ibus_adr_o,
	input logic ibus_ack_i,
	input logic [datW-1:0] ibus_dat_i,

	output logic dbus_cyc_o,
	output logic dbus_stb_o,
	output logic dbus_we_o,
	output logic [adrW-1:0] dbus_adr_o,
	output logic [datW-1:0] dbus_dat_o,
	output logic [datW/8-1:0] dbus_sel_o,
	input logic [datW-1:0] dbus_dat_i,
	input logic dbus_ack_i
);

	wbIf ibus ();
	wbIf dbus ();
	issueIf issue ();
	memReqIf memReq ();

	// instruction side is read only
	assign ibus_cyc_o = ibus.cyc;
	assign ibus_stb_o = ibus.stb;
	assign ibus_adr_o = ibus.adr;
	assign ibus.ack = ibus_ack_i;
	assign ibus.datR = ibus_dat_i;

	assign dbus_cyc_o = dbus.cyc;
	assign dbus_stb_o = dbus.stb;
	assign dbus_we_o = dbus.we;
	assign dbus_adr_o = dbus.adr;
	assign dbus_dat_o = dbus.datW;
	assign dbus_sel_o = dbus.sel;
	assign dbus.ack = dbus_ack_i;
	assign dbus.datR = dbus_dat_i;

	fetchUnit uFetch (
		.clk_mem (clk_mem),
		.rst     (rst),
		.ibus    (ibus.master),
		.issue   (issue.fetch)
	);

	execUnit uExec (
		.clk_mem (clk_mem),
		.rst     (rst),
		.issue   (issue.exec),
		.memReq  (memReq.requester)
	);

	lsuUnit uLsu (
		.clk_mem (clk_mem),
		.rst     (rst),
		.memReq  (memReq.server),
		.dbus    (dbus.master)
	);

endmodule

`default_nettype wire

// File: hdl/lsuUnit.sv
`timescale 1ns/1ps
`default_nettype none

module lsuUnit import wbBusPkg::*; (
	input logic clk_mem,
	input logic rst,
	memReqIf.server memReq,
	wbIf.master dbus
);

	logic cycQ;
	logic stbQ;
	logic weQ;
	logic [adrW-1:0] adrQ;
	logic [datW-1:0] datQ;
	logic start;

	// one bus cycle per request
	assign start = memReq.req && !cycQ;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			cycQ <= 1'b0;
			stbQ <= 1'b0;
			weQ <= 1'b0;
		end else if (cycQ && dbus.ack) begin
			cycQ <= 1'b0;
			stbQ <= 1'b0;
			weQ <= 1'b0;
		end else if (start) begin
			cycQ <= 1'b1;
			stbQ <= 1'b1;
			weQ <= memReq.we;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (start) begin
			adrQ <= memReq.addr;
			datQ <= memReq.wdata;
		end
	end

	assign dbus.cyc = cycQ;
	assign dbus.stb = stbQ;
	assign dbus.we = weQ;
	assign dbus.adr = adrQ;
	assign dbus.datW = datQ;
	assign dbus.sel = '1;

	assign memReq.done = cycQ && dbus.ack;
	assign memReq.rdata = dbus.datR;

	aStbCyc: assert property (@(posedge clk_mem) disable iff (rst) dbus.stb |-> dbus.cyc);

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvIsaPkg::*, wbBusPkg::*; (
	input logic clk_mem,
	input logic rst,
	issueIf.exec issue,
	memReqIf.requester memReq
);

	function automatic decodedT decode(input logic [31:0] ins);
		decodedT d;
		d.op = ins[6:0];
		d.rd = ins[11:7];
		d.rs1 = ins[19:15];
		d.rs2 = ins[24:20];
		d.brNe = ins[12];
		d.imm = {{20{ins[31]}}, ins[31:20]};
		d.aluOp = aluAdd;
		case (ins[6:0])
			opLui: begin
				d.imm = {ins[31:12], 12'b0};
				d.aluOp = aluPassB;
			end
			opOp: begin
				case (ins[14:12])
					f3AddSub: d.aluOp = ins[30] ? aluSub : aluAdd;
					f3Slt: d.aluOp = aluSlt;
					f3Xor: d.aluOp = aluXor;
					f3Or: d.aluOp = aluOr;
					f3And: d.aluOp = aluAnd;
					default: d.aluOp = aluAdd;
				endcase
			end
			opStore: d.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			opBranch: begin
				d.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				d.aluOp = aluSub;
			end
			opJal: d.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default: ;
		endcase
		return d;
	endfunction

	logic [datW-1:0] regs [regCount];

	decodedT dec;
	logic [datW-1:0] rs1Val;
	logic [datW-1:0] rs2Val;
	logic [datW-1:0] opB;
	logic [datW-1:0] aluRes;
	logic [datW-1:0] wbData;
	logic [adrW-1:0] pcPlus4;
	logic [adrW-1:0] target;
	logic isMem;
	logic regWrite;
	logic taken;
	logic done;

	assign dec = decode(issue.instr);

	// x0 reads as zero
	assign rs1Val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
	assign rs2Val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

	assign opB = (dec.op == opOp || dec.op == opBranch) ? rs2Val : dec.imm;

	always_comb begin
		case (dec.aluOp)
			aluAdd: aluRes = rs1Val + opB;
			aluSub: aluRes = rs1Val - opB;
			aluAnd: aluRes = rs1Val & opB;
			aluOr: aluRes = rs1Val | opB;
			aluXor: aluRes = rs1Val ^ opB;
			aluSlt: aluRes = ($signed(rs1Val) < $signed(opB)) ? 32'd1 : 32'd0;
			default: aluRes = opB;
		endcase
	end

	// beq/bne from the subtract result
	assign taken = (dec.op == opJal) ||
		(dec.op == opBranch && ((aluRes == '0) ^ dec.brNe));

	assign pcPlus4 = issue.pc + 32'd4;
	assign target = issue.pc + dec.imm;

	assign isMem = (dec.op == opLoad) || (dec.op == opStore);
	assign regWrite = (dec.op == opLui) || (dec.op == opOpImm) || (dec.op == opOp) ||
		(dec.op == opLoad) || (dec.op == opJal);

	always_comb begin
		if (dec.op == opJal) begin
			wbData = pcPlus4;
		end else if (dec.op == opLoad) begin
			wbData = memReq.rdata;
		end else begin
			wbData = aluRes;
		end
	end

	// memory ops wait for the lsu, the rest finish in their first valid cycle
	assign done = issue.valid && (!isMem || memReq.done);

	always_ff @(posedge clk_mem) begin
		if (done && regWrite && dec.rd != 5'd0) begin
			regs[dec.rd] <= wbData;
		end
	end

	assign issue.done = done;
	assign issue.nextPc = taken ? target : pcPlus4;

	assign memReq.req = issue.valid && isMem;
	assign memReq.we = (dec.op == opStore);
	assign memReq.addr = aluRes;
	assign memReq.wdata = rs2Val;

	aReqMemOnly: assert property (@(posedge clk_mem) disable iff (rst)
		memReq.req |-> issue.instr[6:0] == opLoad || issue.instr[6:0] == opStore);

	// request stays up until the lsu answers
	aReqHeld: assert property (@(posedge clk_mem) disable iff (rst)
		memReq.req && !memReq.done |=> memReq.req);

endmodule

`default_nettype wire

// File: hdl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import wbBusPkg::*; (
	input logic clk_mem,
	input logic rst,
	wbIf.master ibus,
	issueIf.fetch issue
);

	logic [adrW-1:0] pcQ;
	logic [datW-1:0] instrQ;
	logic cycQ;
	logic stbQ;
	logic validQ;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			pcQ <= resetPc;
			cycQ <= 1'b0;
			stbQ <= 1'b0;
			validQ <= 1'b0;
		end else if (issue.done) begin
			// retire and go straight to the next fetch
			pcQ <= issue.nextPc;
			validQ <= 1'b0;
			cycQ <= 1'b1;
			stbQ <= 1'b1;
		end else if (cycQ && ibus.ack) begin
			cycQ <= 1'b0;
			stbQ <= 1'b0;
			validQ <= 1'b1;
		end else if (!cycQ && !validQ) begin
			// first fetch out of reset
			cycQ <= 1'b1;
			stbQ <= 1'b1;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (cycQ && ibus.ack) begin
			instrQ <= ibus.datR;
		end
	end

	assign ibus.cyc = cycQ;
	assign ibus.stb = stbQ;
	assign ibus.we = 1'b0;
	assign ibus.adr = pcQ;
	assign ibus.datW = '0;
	assign ibus.sel = '1;

	assign issue.valid = validQ;
	assign issue.instr = instrQ;
	assign issue.pc = pcQ;

	aStbCyc: assert property (@(posedge clk_mem) disable iff (rst) ibus.stb |-> ibus.cyc);

	aAdrHold: assert property (@(posedge clk_mem) disable iff (rst)
		ibus.stb && !ibus.ack |=> ibus.stb && $stable(ibus.adr));

endmodule

`default_nettype wire

// File: hdl/coreIfs.sv
`timescale 1ns/1ps
`default_nettype none

// signal datW shares its name with the package width, so widths are scoped here
interface wbIf;
	logic                          cyc;
	logic                          stb;
	logic                          we;
	logic [wbBusPkg::adrW-1:0]     adr;
	logic [wbBusPkg::datW-1:0]     datW;
	logic [wbBusPkg::datW-1:0]     datR;
	logic [wbBusPkg::datW/8-1:0]   sel;
	logic                          ack;

	modport master (output cyc, stb, we, adr, datW, sel, input datR, ack);
	modport slave (input cyc, stb, we, adr, datW, sel, output datR, ack);
endinterface

interface issueIf import wbBusPkg::*; ();
	logic            valid;
	logic [datW-1:0] instr;
	logic [adrW-1:0] pc;
	logic            done;
	logic [adrW-1:0] nextPc;

	modport fetch (output valid, instr, pc, input done, nextPc);
	modport exec (input valid, instr, pc, output done, nextPc);
endinterface

interface memReqIf import wbBusPkg::*; ();
	logic            req;
	logic            we;
	logic [adrW-1:0] addr;
	logic [datW-1:0] wdata;
	logic [datW-1:0] rdata;
	logic            done;

	modport requester (output req, we, addr, wdata, input rdata, done);
	modport server (input req, we, addr, wdata, output rdata, done);
endinterface

`default_nettype wire

// File: hdl/wbBusPkg.sv
`default_nettype none

package wbBusPkg;

	localparam int adrW = 32;
	localparam int datW = 32;

	// first fetch address after reset
	localparam logic [adrW-1:0] resetPc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	localparam int regCount = 32;

	// base opcodes, instr[6:0]
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;

	// funct3 values for OP
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOpT;

	// op keeps the opcode as operation class
	typedef struct packed {
		logic [6:0]  op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic        brNe;
		aluOpT       aluOp;
	} decodedT;

endpackage

`default_nettype wire
